// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cap_lsu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
rtl/cap_lsu_pkg.sv
rtl/lsu_req_if.sv
rtl/cap_bounds_checker.sv
rtl/data_mem_port.sv
rtl/mem_trace.sv
rtl/cap_lsu_top.sv
test/tb_clock_gen.sv
test/cap_lsu_checker.sv
test/tb_cap_lsu.sv

// ==== rtl/cap_bounds_checker.sv ====
module cap_bounds_checker (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  cap_lsu_pkg::access_size_t req_size_i,
  input  cap_lsu_pkg::addr_t        req_addr_i,
  input  cap_lsu_pkg::data_t        req_wdata_i,
  input  cap_lsu_pkg::addr_t        cap_base_i,
  input  cap_lsu_pkg::cap_len_t     cap_length_i,
  input  cap_lsu_pkg::cap_perms_t   cap_perms_i,
  input  logic                      cap_tag_i,
  lsu_req_if.chk                    out_o
);

  logic                   en_q;
  logic                   valid_q;
  logic                   req_fire;
  logic [2:0]             nbytes;
  cap_lsu_pkg::be_t       size_mask;
  logic                   misaligned;
  logic [33:0]            acc_end;
  logic [33:0]            cap_end;
  logic                   out_of_bounds;
  cap_lsu_pkg::exc_code_t exc_d;

  ////////////////////////////////////////////////////////////////////////////
  // Capability check
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_size_i)
      cap_lsu_pkg::SizeByte: begin
        nbytes    = 3'd1;
        size_mask = 4'b0001;
      end
      cap_lsu_pkg::SizeHalf: begin
        nbytes    = 3'd2;
        size_mask = 4'b0011;
      end
      default: begin
        nbytes    = 3'd4;
        size_mask = 4'b1111;
      end
    endcase
  end

  assign misaligned = (req_size_i == cap_lsu_pkg::SizeHalf) ? req_addr_i[0] :
                      (req_size_i == cap_lsu_pkg::SizeByte) ? 1'b0 :
                      (req_addr_i[1:0] != 2'b00);

  // End points are exclusive, kept in 34 bits so base plus length never wraps
  assign acc_end       = {2'b00, req_addr_i} + {31'b0, nbytes};
  assign cap_end       = {2'b00, cap_base_i} + {1'b0, cap_length_i};
  assign out_of_bounds = (req_addr_i < cap_base_i) || (acc_end > cap_end);

  // First failing test wins
  always_comb begin
    if (!cap_tag_i) begin
      exc_d = cap_lsu_pkg::ExcTag;
    end else if (req_we_i && !cap_perms_i[cap_lsu_pkg::PermStoreBit]) begin
      exc_d = cap_lsu_pkg::ExcPermStore;
    end else if (!req_we_i && !cap_perms_i[cap_lsu_pkg::PermLoadBit]) begin
      exc_d = cap_lsu_pkg::ExcPermLoad;
    end else if (misaligned) begin
      exc_d = cap_lsu_pkg::ExcAlign;
    end else if (out_of_bounds) begin
      exc_d = cap_lsu_pkg::ExcBounds;
    end else begin
      exc_d = cap_lsu_pkg::ExcNone;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request register
  ////////////////////////////////////////////////////////////////////////////

  // Closed in reset and for the first cycle after it
  assign req_ready_o = en_q & (~valid_q | out_o.ready);
  assign req_fire    = req_valid_i & req_ready_o;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      en_q <= 1'b1;
      if (req_ready_o) begin
        valid_q <= req_valid_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      out_o.we    <= req_we_i;
      out_o.size  <= req_size_i;
      out_o.addr  <= req_addr_i;
      out_o.be    <= size_mask << req_addr_i[1:0];
      out_o.wdata <= req_wdata_i << {req_addr_i[1:0], 3'b000};
      out_o.exc   <= exc_d;
    end
  end

  assign out_o.valid = valid_q;

endmodule

// ==== rtl/cap_lsu_pkg.sv ====
package cap_lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // One bit wider than an address so a capability can span all of memory
  typedef logic [32:0] cap_len_t;

  ////////////////////////////////////////////////////////////////////////////
  // Capability permissions
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [1:0] cap_perms_t;

  localparam int unsigned PermLoadBit  = 0;
  localparam int unsigned PermStoreBit = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Access size and exception encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [1:0] access_size_t;

  // Encoding 3 is reserved and handled as a word
  localparam access_size_t SizeWord = 2'd0;
  localparam access_size_t SizeHalf = 2'd1;
  localparam access_size_t SizeByte = 2'd2;

  typedef logic [2:0] exc_code_t;

  localparam exc_code_t ExcNone      = 3'd0;
  localparam exc_code_t ExcTag       = 3'd1;
  localparam exc_code_t ExcPermLoad  = 3'd2;
  localparam exc_code_t ExcPermStore = 3'd3;
  localparam exc_code_t ExcBounds    = 3'd4;
  localparam exc_code_t ExcAlign     = 3'd5;
  localparam exc_code_t ExcBus       = 3'd6;

  ////////////////////////////////////////////////////////////////////////////
  // Memory port FSM
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PortIdle,
    PortWaitGnt,
    PortWaitRvalid
  } mem_port_state_e;

endpackage

// ==== rtl/cap_lsu_top.sv ====
module cap_lsu_top #(
  parameter int unsigned TraceOrderWidth = 64
) (
  input  logic                       clk,
  input  logic                       rst_ni,

  // Request with its capability
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic                       req_we_i,
  input  cap_lsu_pkg::access_size_t  req_size_i,
  input  cap_lsu_pkg::addr_t         req_addr_i,
  input  cap_lsu_pkg::data_t         req_wdata_i,
  input  cap_lsu_pkg::addr_t         cap_base_i,
  input  cap_lsu_pkg::cap_len_t      cap_length_i,
  input  cap_lsu_pkg::cap_perms_t    cap_perms_i,
  input  logic                       cap_tag_i,

  // Response, no back-pressure
  output logic                       resp_valid_o,
  output cap_lsu_pkg::data_t         resp_rdata_o,
  output cap_lsu_pkg::exc_code_t     resp_exc_o,

  // Data bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_err_i,
  output logic                       data_we_o,
  output cap_lsu_pkg::be_t           data_be_o,
  output cap_lsu_pkg::addr_t         data_addr_o,
  output cap_lsu_pkg::data_t         data_wdata_o,
  input  cap_lsu_pkg::data_t         data_rdata_i,

  // Retirement trace
  output logic                       trace_valid_o,
  output logic [TraceOrderWidth-1:0] trace_order_o,
  output cap_lsu_pkg::addr_t         trace_addr_o,
  output cap_lsu_pkg::be_t           trace_rmask_o,
  output cap_lsu_pkg::be_t           trace_wmask_o,
  output cap_lsu_pkg::data_t         trace_rdata_o,
  output cap_lsu_pkg::data_t         trace_wdata_o,
  output logic                       trace_trap_o,

  output logic                       busy_o
);

  cap_lsu_pkg::addr_t resp_addr;
  cap_lsu_pkg::be_t   resp_be;
  logic               resp_we;
  cap_lsu_pkg::data_t resp_wdata;
  logic               port_idle;
  logic               busy_d;
  logic               busy_q;

  lsu_req_if u_req_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Checker stage and memory port
  ////////////////////////////////////////////////////////////////////////////

  cap_bounds_checker u_checker (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_we_i     (req_we_i),
    .req_size_i   (req_size_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .cap_base_i   (cap_base_i),
    .cap_length_i (cap_length_i),
    .cap_perms_i  (cap_perms_i),
    .cap_tag_i    (cap_tag_i),
    .out_o        (u_req_if.chk)
  );

  data_mem_port u_port (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .in_i          (u_req_if.port),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_err_i    (data_err_i),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .resp_valid_o  (resp_valid_o),
    .resp_exc_o    (resp_exc_o),
    .resp_rdata_o  (resp_rdata_o),
    .resp_addr_o   (resp_addr),
    .resp_be_o     (resp_be),
    .resp_we_o     (resp_we),
    .resp_wdata_o  (resp_wdata),
    .idle_o        (port_idle)
  );

  mem_trace #(
    .TraceOrderWidth (TraceOrderWidth)
  ) u_trace (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .resp_valid_i  (resp_valid_o),
    .resp_exc_i    (resp_exc_o),
    .resp_rdata_i  (resp_rdata_o),
    .resp_addr_i   (resp_addr),
    .resp_be_i     (resp_be),
    .resp_we_i     (resp_we),
    .resp_wdata_i  (resp_wdata),
    .trace_valid_o (trace_valid_o),
    .trace_order_o (trace_order_o),
    .trace_addr_o  (trace_addr_o),
    .trace_rmask_o (trace_rmask_o),
    .trace_wmask_o (trace_wmask_o),
    .trace_rdata_o (trace_rdata_o),
    .trace_wdata_o (trace_wdata_o),
    .trace_trap_o  (trace_trap_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Busy flag
  ////////////////////////////////////////////////////////////////////////////

  // Held item or bus access in flight, seen one cycle late
  assign busy_d = u_req_if.valid | ~port_idle;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
    end
  end

  assign busy_o = busy_q;

endmodule

// ==== rtl/data_mem_port.sv ====
module data_mem_port (
  input  logic                   clk,
  input  logic                   rst_ni,
  lsu_req_if.port                in_i,

  // Data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output logic                   data_we_o,
  output cap_lsu_pkg::be_t       data_be_o,
  output cap_lsu_pkg::addr_t     data_addr_o,
  output cap_lsu_pkg::data_t     data_wdata_o,
  input  cap_lsu_pkg::data_t     data_rdata_i,

  // Response
  output logic                   resp_valid_o,
  output cap_lsu_pkg::exc_code_t resp_exc_o,
  output cap_lsu_pkg::data_t     resp_rdata_o,
  output cap_lsu_pkg::addr_t     resp_addr_o,
  output cap_lsu_pkg::be_t       resp_be_o,
  output logic                   resp_we_o,
  output cap_lsu_pkg::data_t     resp_wdata_o,
  output logic                   idle_o
);

  cap_lsu_pkg::mem_port_state_e state_q;
  cap_lsu_pkg::mem_port_state_e state_d;

  logic                      accept;
  logic                      refused;
  logic                      bus_done;
  logic                      resp_valid_q;
  cap_lsu_pkg::exc_code_t    resp_exc_q;
  cap_lsu_pkg::data_t        resp_rdata_q;
  cap_lsu_pkg::data_t        rdata_shift;
  cap_lsu_pkg::data_t        rdata_ext;

  // Payload of the item in service
  logic                      we_q;
  cap_lsu_pkg::access_size_t size_q;
  cap_lsu_pkg::addr_t        addr_q;
  cap_lsu_pkg::be_t          be_q;
  cap_lsu_pkg::data_t        wdata_q;

  assign in_i.ready = (state_q == cap_lsu_pkg::PortIdle);
  assign accept     = in_i.valid & in_i.ready;
  assign refused    = accept & (in_i.exc != cap_lsu_pkg::ExcNone);
  assign bus_done   = (state_q == cap_lsu_pkg::PortWaitRvalid) & data_rvalid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Bus FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      cap_lsu_pkg::PortIdle: begin
        // Refused items stay here and answer without the bus
        if (accept && !refused) begin
          state_d = cap_lsu_pkg::PortWaitGnt;
        end
      end
      cap_lsu_pkg::PortWaitGnt: begin
        if (data_gnt_i) begin
          state_d = cap_lsu_pkg::PortWaitRvalid;
        end
      end
      cap_lsu_pkg::PortWaitRvalid: begin
        if (data_rvalid_i) begin
          state_d = cap_lsu_pkg::PortIdle;
        end
      end
      default: state_d = cap_lsu_pkg::PortIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= cap_lsu_pkg::PortIdle;
      resp_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      resp_valid_q <= refused | bus_done;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= in_i.we;
      size_q  <= in_i.size;
      addr_q  <= in_i.addr;
      be_q    <= in_i.be;
      wdata_q <= in_i.wdata;
    end
  end

  // Held steady from the request until the grant
  assign data_req_o   = (state_q == cap_lsu_pkg::PortWaitGnt);
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_addr_o  = {addr_q[31:2], 2'b00};
  assign data_wdata_o = wdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_shift = data_rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (size_q)
      cap_lsu_pkg::SizeByte: rdata_ext = {24'b0, rdata_shift[7:0]};
      cap_lsu_pkg::SizeHalf: rdata_ext = {16'b0, rdata_shift[15:0]};
      default:               rdata_ext = rdata_shift;
    endcase
  end

  always_ff @(posedge clk) begin
    if (refused) begin
      resp_exc_q   <= in_i.exc;
      resp_rdata_q <= '0;
    end else if (bus_done) begin
      resp_exc_q   <= data_err_i ? cap_lsu_pkg::ExcBus : cap_lsu_pkg::ExcNone;
      // Stores and failed loads return zero
      resp_rdata_q <= (we_q || data_err_i) ? '0 : rdata_ext;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_exc_o   = resp_exc_q;
  assign resp_rdata_o = resp_rdata_q;
  assign resp_addr_o  = addr_q;
  assign resp_be_o    = be_q;
  assign resp_we_o    = we_q;
  assign resp_wdata_o = wdata_q;
  assign idle_o       = (state_q == cap_lsu_pkg::PortIdle);

endmodule

// ==== rtl/lsu_req_if.sv ====
interface lsu_req_if;

  logic                      valid;
  logic                      ready;
  logic                      we;
  cap_lsu_pkg::access_size_t size;
  cap_lsu_pkg::addr_t        addr;
  cap_lsu_pkg::be_t          be;
  cap_lsu_pkg::data_t        wdata;
  // ExcNone for an access that may go to the bus
  cap_lsu_pkg::exc_code_t    exc;

  // Bounds checker side
  modport chk (
    output valid, we, size, addr, be, wdata, exc,
    input  ready
  );

  // Memory port side
  modport port (
    input  valid, we, size, addr, be, wdata, exc,
    output ready
  );

endinterface

// ==== rtl/mem_trace.sv ====
module mem_trace #(
  parameter int unsigned TraceOrderWidth = 64
) (
  input  logic                       clk,
  input  logic                       rst_ni,

  input  logic                       resp_valid_i,
  input  cap_lsu_pkg::exc_code_t     resp_exc_i,
  input  cap_lsu_pkg::data_t         resp_rdata_i,
  input  cap_lsu_pkg::addr_t         resp_addr_i,
  input  cap_lsu_pkg::be_t           resp_be_i,
  input  logic                       resp_we_i,
  input  cap_lsu_pkg::data_t         resp_wdata_i,

  output logic                       trace_valid_o,
  output logic [TraceOrderWidth-1:0] trace_order_o,
  output cap_lsu_pkg::addr_t         trace_addr_o,
  output cap_lsu_pkg::be_t           trace_rmask_o,
  output cap_lsu_pkg::be_t           trace_wmask_o,
  output cap_lsu_pkg::data_t         trace_rdata_o,
  output cap_lsu_pkg::data_t         trace_wdata_o,
  output logic                       trace_trap_o
);

  // Order of a record is the number of records emitted before it
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid_o <= 1'b0;
      trace_order_o <= '0;
    end else begin
      trace_valid_o <= resp_valid_i;
      trace_order_o <= trace_order_o + TraceOrderWidth'(trace_valid_o);
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (resp_valid_i) begin
      trace_addr_o  <= resp_addr_i;
      trace_rmask_o <= resp_we_i ? 4'b0000 : resp_be_i;
      trace_wmask_o <= resp_we_i ? resp_be_i : 4'b0000;
      trace_rdata_o <= resp_rdata_i;
      trace_wdata_o <= resp_we_i ? resp_wdata_i : '0;
      trace_trap_o  <= (resp_exc_i != cap_lsu_pkg::ExcNone);
    end
  end

endmodule

// ==== test/cap_lsu_checker.sv ====
module cap_lsu_checker #(
  parameter int unsigned TraceOrderWidth = 64
) (
  input logic                       clk,
  input logic                       rst_ni,
  input logic                       req_ready_o,
  input logic                       resp_valid_o,
  input logic                       data_req_o,
  input logic                       data_gnt_i,
  input logic                       data_we_o,
  input logic [3:0]                 data_be_o,
  input logic [31:0]                data_addr_o,
  input logic [31:0]                data_wdata_o,
  input logic                       trace_valid_o,
  input logic [TraceOrderWidth-1:0] trace_order_o,
  input logic                       busy_o,
  input logic                       refused_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Bus request and payload held until the grant
  assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_we_o) && $stable(data_be_o)
      && $stable(data_addr_o) && $stable(data_wdata_o))
    else begin
      $error("bus request changed before its grant");
      fail_count++;
    end

  // Trace record exactly one cycle after each response
  assert property (@(posedge clk) disable iff (!rst_ni)
    resp_valid_o |=> trace_valid_o)
    else begin
      $error("response without a trace record one cycle later");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_ni)
    !resp_valid_o |=> !trace_valid_o)
    else begin
      $error("trace record without a response");
      fail_count++;
    end

  assert property (@(posedge clk)
    !rst_ni |-> !req_ready_o && !resp_valid_o && !data_req_o && !trace_valid_o
      && !busy_o && (trace_order_o == '0))
    else begin
      $error("output active during reset");
      fail_count++;
    end

  // A refused item never reaches the bus
  assert property (@(posedge clk) disable iff (!rst_ni)
    refused_i |=> !data_req_o)
    else begin
      $error("bus request after a refused item");
      fail_count++;
    end

endmodule

bind cap_lsu_top cap_lsu_checker #(
  .TraceOrderWidth (TraceOrderWidth)
) u_sva (
  .clk           (clk),
  .rst_ni        (rst_ni),
  .req_ready_o   (req_ready_o),
  .resp_valid_o  (resp_valid_o),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_we_o     (data_we_o),
  .data_be_o     (data_be_o),
  .data_addr_o   (data_addr_o),
  .data_wdata_o  (data_wdata_o),
  .trace_valid_o (trace_valid_o),
  .trace_order_o (trace_order_o),
  .busy_o        (busy_o),
  .refused_i     (u_port.refused)
);

// ==== test/tb_cap_lsu.sv ====
module tb_cap_lsu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TimeoutCycles = 300;

  logic        clk;
  logic        rst_ni;
  logic        req_valid_i;
  logic        req_ready_o;
  logic        req_we_i;
  logic [1:0]  req_size_i;
  logic [31:0] req_addr_i;
  logic [31:0] req_wdata_i;
  logic [31:0] cap_base_i;
  logic [32:0] cap_length_i;
  logic [1:0]  cap_perms_i;
  logic        cap_tag_i;
  logic        resp_valid_o;
  logic [31:0] resp_rdata_o;
  logic [2:0]  resp_exc_o;
  logic        data_req_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic        data_err_i;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i;
  logic        trace_valid_o;
  logic [63:0] trace_order_o;
  logic [31:0] trace_addr_o;
  logic [3:0]  trace_rmask_o;
  logic [3:0]  trace_wmask_o;
  logic [31:0] trace_rdata_o;
  logic [31:0] trace_wdata_o;
  logic        trace_trap_o;
  logic        busy_o;

  // Bus memory and the reference copy used for predictions
  logic [31:0] mem [256];
  logic [31:0] ref_mem [256];

  logic [31:0] cur_base;
  logic [32:0] cur_len;
  logic [1:0]  cur_perms;
  logic        cur_tag;

  string       exp_name_q[$];
  logic [2:0]  exp_exc_q[$];
  logic [31:0] exp_rdata_q[$];
  string       trace_name_q[$];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_trdata_q[$];
  logic [31:0] exp_twdata_q[$];
  logic [3:0]  exp_rmask_q[$];
  logic [3:0]  exp_wmask_q[$];
  logic        exp_trap_q[$];
  logic        bus_err_q[$];
  logic [3:0]  bus_be_q[$];
  logic [31:0] bus_addr_q[$];

  longint      trace_count;
  bit          saw_stall;
  bit          saw_busy;

  tb_clock_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_ni)
  );

  cap_lsu_top #(
    .TraceOrderWidth (64)
  ) u_dut (.*);

  task automatic abort_run(input string what);
    $display("error: %s", what);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("mismatch %s expected %0h actual %0h", name, exp, act);
      abort_run("wrong value");
    end
  endtask

  function automatic logic [3:0] size_mask(input logic [1:0] size);
    case (size)
      cap_lsu_pkg::SizeByte: return 4'b0001;
      cap_lsu_pkg::SizeHalf: return 4'b0011;
      default:               return 4'b1111;
    endcase
  endfunction

  function automatic logic [2:0] expect_exc(input logic we, input logic [1:0] size,
                                            input logic [31:0] addr);
    logic [33:0] last;
    int          n;
    n    = (size == cap_lsu_pkg::SizeByte) ? 1 : (size == cap_lsu_pkg::SizeHalf) ? 2 : 4;
    last = 34'(addr) + 34'(n);
    if (!cur_tag) return cap_lsu_pkg::ExcTag;
    if (we && !cur_perms[1]) return cap_lsu_pkg::ExcPermStore;
    if (!we && !cur_perms[0]) return cap_lsu_pkg::ExcPermLoad;
    if ((n == 2 && addr[0]) || (n == 4 && addr[1:0] != 2'b00)) return cap_lsu_pkg::ExcAlign;
    if (addr < cur_base || last > 34'(cur_base) + 34'(cur_len)) return cap_lsu_pkg::ExcBounds;
    return cap_lsu_pkg::ExcNone;
  endfunction

  task automatic set_cap(input logic [31:0] base, input logic [32:0] len,
                         input logic [1:0] perms, input logic tag);
    cur_base  = base;
    cur_len   = len;
    cur_perms = perms;
    cur_tag   = tag;
  endtask

  // Called on a rising edge; returns on the edge where the request transfers
  task automatic send_req(input string name, input logic we, input logic [1:0] size,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic inject_err);
    logic [2:0]  exc;
    logic [3:0]  be;
    logic [31:0] wshift;
    logic [31:0] rd;
    int          cnt;
    req_valid_i  <= 1'b1;
    req_we_i     <= we;
    req_size_i   <= size;
    req_addr_i   <= addr;
    req_wdata_i  <= wdata;
    cap_base_i   <= cur_base;
    cap_length_i <= cur_len;
    cap_perms_i  <= cur_perms;
    cap_tag_i    <= cur_tag;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > TimeoutCycles) abort_run({"request never accepted: ", name});
    end while (!req_ready_o);
    if (cnt > 1) saw_stall = 1'b1;

    exc    = expect_exc(we, size, addr);
    be     = size_mask(size) << addr[1:0];
    wshift = wdata << (8 * addr[1:0]);
    rd     = '0;
    if (exc == cap_lsu_pkg::ExcNone) begin
      bus_err_q.push_back(inject_err);
      bus_be_q.push_back(be);
      bus_addr_q.push_back({addr[31:2], 2'b00});
      if (inject_err) begin
        exc = cap_lsu_pkg::ExcBus;
      end else if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) ref_mem[addr[9:2]][8*b +: 8] = wshift[8*b +: 8];
        end
      end else begin
        rd = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
        if (size == cap_lsu_pkg::SizeByte) rd = rd & 32'h0000_00ff;
        if (size == cap_lsu_pkg::SizeHalf) rd = rd & 32'h0000_ffff;
      end
    end
    exp_name_q.push_back(name);
    exp_exc_q.push_back(exc);
    exp_rdata_q.push_back(rd);
    trace_name_q.push_back(name);
    exp_addr_q.push_back(addr);
    exp_trdata_q.push_back(rd);
    exp_twdata_q.push_back(we ? wshift : 32'h0);
    exp_rmask_q.push_back(we ? 4'b0000 : be);
    exp_wmask_q.push_back(we ? be : 4'b0000);
    exp_trap_q.push_back(exc != cap_lsu_pkg::ExcNone);
  endtask

  task automatic drain(input string name);
    int cnt;
    req_valid_i <= 1'b0;
    cnt = 0;
    while (exp_exc_q.size() != 0 || exp_trap_q.size() != 0) begin
      @(posedge clk);
      cnt++;
      if (cnt > TimeoutCycles) abort_run({"unit did not drain after ", name});
    end
    check_eq({"busy after ", name}, 0, busy_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model on the data bus
  ////////////////////////////////////////////////////////////////////////////

  int          gnt_wait;
  int          rv_wait;
  bit          rv_pending;
  logic        acc_err;
  logic [7:0]  acc_idx;

  always @(posedge clk) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    data_err_i    <= 1'b0;
    if (!rst_ni) begin
      rv_pending = 1'b0;
      gnt_wait   = 0;
    end else if (rv_pending) begin
      if (rv_wait == 0) begin
        data_rvalid_i <= 1'b1;
        data_err_i    <= acc_err;
        data_rdata_i  <= mem[acc_idx];
        rv_pending = 1'b0;
      end else begin
        rv_wait--;
      end
    end else if (data_req_o && data_gnt_i) begin
      if (bus_be_q.size() == 0) abort_run("bus access without a checked request");
      check_eq("bus byte enables", bus_be_q.pop_front(), data_be_o);
      check_eq("bus address", bus_addr_q.pop_front(), data_addr_o);
      acc_err = bus_err_q.pop_front();
      acc_idx = data_addr_o[9:2];
      if (data_we_o && !acc_err) begin
        for (int b = 0; b < 4; b++) begin
          if (data_be_o[b]) mem[acc_idx][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
      end
      rv_wait  = $urandom_range(1, 3);
      gnt_wait = $urandom_range(0, 3);
      if (rv_wait == 1) begin
        data_rvalid_i <= 1'b1;
        data_err_i    <= acc_err;
        data_rdata_i  <= mem[acc_idx];
      end else begin
        rv_wait    = rv_wait - 2;
        rv_pending = 1'b1;
      end
    end else if (data_req_o) begin
      if (gnt_wait == 0) data_gnt_i <= 1'b1;
      else gnt_wait--;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response and trace monitors
  ////////////////////////////////////////////////////////////////////////////

  string resp_name;
  string trace_name;

  always @(posedge clk) begin
    if (u_dut.u_sva.fail_count != 0) abort_run("an assertion in the bound checker failed");
    if (rst_ni && busy_o) saw_busy = 1'b1;
    if (rst_ni && resp_valid_o) begin
      if (exp_exc_q.size() == 0) abort_run("response without a request");
      resp_name = exp_name_q.pop_front();
      check_eq({resp_name, " exc"}, exp_exc_q.pop_front(), resp_exc_o);
      check_eq({resp_name, " rdata"}, exp_rdata_q.pop_front(), resp_rdata_o);
    end
    if (rst_ni && trace_valid_o) begin
      if (exp_trap_q.size() == 0) abort_run("trace record without a response");
      trace_name = trace_name_q.pop_front();
      check_eq({trace_name, " trace order"}, trace_count, trace_order_o);
      check_eq({trace_name, " trace addr"}, exp_addr_q.pop_front(), trace_addr_o);
      check_eq({trace_name, " trace rmask"}, exp_rmask_q.pop_front(), trace_rmask_o);
      check_eq({trace_name, " trace wmask"}, exp_wmask_q.pop_front(), trace_wmask_o);
      check_eq({trace_name, " trace rdata"}, exp_trdata_q.pop_front(), trace_rdata_o);
      check_eq({trace_name, " trace wdata"}, exp_twdata_q.pop_front(), trace_wdata_o);
      check_eq({trace_name, " trace trap"}, exp_trap_q.pop_front(), trace_trap_o);
      trace_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          cnt;
    logic [1:0]  size;
    logic [31:0] addr;
    void'($urandom(32'h58fd));
    req_valid_i   = 1'b0;
    req_we_i      = 1'b0;
    req_size_i    = '0;
    req_addr_i    = '0;
    req_wdata_i   = '0;
    cap_base_i    = '0;
    cap_length_i  = '0;
    cap_perms_i   = '0;
    cap_tag_i     = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    trace_count   = 0;
    saw_stall     = 1'b0;
    saw_busy      = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'(i * 7) ^ 8'hc3};
      ref_mem[i] = mem[i];
    end

    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > TimeoutCycles) abort_run("reset never released");
    end while (!rst_ni);
    @(posedge clk);
    check_eq("busy after reset", 0, busy_o);

    // Stores of each size, then loads at every legal offset
    set_cap(32'h0, 33'd1024, 2'b11, 1'b1);
    send_req("store_word", 1'b1, cap_lsu_pkg::SizeWord, 32'h10, 32'hdead_beef, 1'b0);
    send_req("store_half", 1'b1, cap_lsu_pkg::SizeHalf, 32'h22, 32'h0000_a55a, 1'b0);
    send_req("store_byte", 1'b1, cap_lsu_pkg::SizeByte, 32'h33, 32'h0000_0077, 1'b0);
    for (int w = 1; w <= 3; w++) begin
      send_req("load_word", 1'b0, cap_lsu_pkg::SizeWord, 32'(w * 16), 32'h0, 1'b0);
      for (int off = 0; off < 4; off += 2) begin
        send_req("load_half", 1'b0, cap_lsu_pkg::SizeHalf, 32'(w * 16 + off), 32'h0, 1'b0);
      end
      for (int off = 0; off < 4; off++) begin
        send_req("load_byte", 1'b0, cap_lsu_pkg::SizeByte, 32'(w * 16 + off), 32'h0, 1'b0);
      end
    end
    drain("aligned accesses");

    // Refused requests, later tests failing as well where possible
    set_cap(32'h100, 33'h10, 2'b00, 1'b0);
    send_req("tag_clear", 1'b0, cap_lsu_pkg::SizeWord, 32'h1fe, 32'h0, 1'b0);
    set_cap(32'h100, 33'h10, 2'b01, 1'b1);
    send_req("no_store_perm", 1'b1, cap_lsu_pkg::SizeWord, 32'h11e, 32'h1, 1'b0);
    set_cap(32'h100, 33'h10, 2'b10, 1'b1);
    send_req("no_load_perm", 1'b0, cap_lsu_pkg::SizeHalf, 32'h121, 32'h0, 1'b0);
    set_cap(32'h100, 33'h10, 2'b11, 1'b1);
    send_req("misaligned_half", 1'b0, cap_lsu_pkg::SizeHalf, 32'h101, 32'h0, 1'b0);
    send_req("misaligned_word", 1'b0, cap_lsu_pkg::SizeWord, 32'h102, 32'h0, 1'b0);
    send_req("odd_half_at_end", 1'b0, cap_lsu_pkg::SizeHalf, 32'h10f, 32'h0, 1'b0);
    send_req("one_past_end", 1'b0, cap_lsu_pkg::SizeByte, 32'h110, 32'h0, 1'b0);
    send_req("below_base", 1'b0, cap_lsu_pkg::SizeWord, 32'hfc, 32'h0, 1'b0);
    send_req("last_word", 1'b0, cap_lsu_pkg::SizeWord, 32'h10c, 32'h0, 1'b0);
    send_req("last_half", 1'b1, cap_lsu_pkg::SizeHalf, 32'h10e, 32'h1234, 1'b0);
    drain("refused requests");

    // Bus error on a granted access
    set_cap(32'h0, 33'd1024, 2'b11, 1'b1);
    send_req("bus_err_load", 1'b0, cap_lsu_pkg::SizeWord, 32'h40, 32'h0, 1'b1);
    send_req("bus_err_store", 1'b1, cap_lsu_pkg::SizeWord, 32'h44, 32'h9, 1'b1);
    drain("bus errors");

    // Back-to-back random traffic against a stalling bus
    for (int i = 0; i < 32; i++) begin
      size = 2'($urandom_range(0, 2));
      addr = 32'($urandom_range(0, 255) * 4);
      if (size == cap_lsu_pkg::SizeHalf) addr = addr + 32'($urandom_range(0, 1) * 2);
      if (size == cap_lsu_pkg::SizeByte) addr = addr + 32'($urandom_range(0, 3));
      send_req("random", 1'($urandom_range(0, 1)), size, addr, $urandom(), 1'b0);
    end
    drain("random traffic");

    if (!saw_stall) abort_run("req_ready_o never dropped under back-pressure");
    if (!saw_busy) abort_run("busy_o never rose during a request");
    if (u_dut.u_sva.fail_count != 0) begin
      abort_run("an assertion in the bound checker failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Start high so that the DUT sees a falling reset edge
  initial begin
    rst_no = 1'b1;
    #1 rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
